//--- cache_addr_pkg.sv
`default_nettype none

package cache_addr_pkg;

   // front-end byte address geometry
   localparam int ADDR_W = 16;
   localparam int TAG_W = 8;
   localparam int INDEX_W = 4;
   localparam int OFFSET_W = 2;
   localparam int BSEL_W = 2;

   // data word
   localparam int WORD_W = 32;
   localparam int NBYTES = 4;

   // address split into its cache fields, msb first
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
      logic [BSEL_W-1:0]   byte_sel;
   } addr_fields_t;

   // raw view for the back end, field view for the arrays
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      addr_fields_t      fields;
   } addr_u;

   typedef struct packed {
      logic              we;
      addr_u             addr;
      logic [WORD_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } fe_req_t;

   typedef struct packed {
      logic [WORD_W-1:0] rdata;
   } fe_rsp_t;

endpackage

`default_nettype wire

//--- cache_decode.sv
`default_nettype none

module cache_decode (
   input  wire                          clk_i,
   input  wire                          reset_i,
   input  wire                          req_i,
   input  wire cache_addr_pkg::fe_req_t fe_req_i,
   output logic                         ack_o,
   input  wire                          fe_done_i,
   output logic                         dec_valid_o,
   output cache_addr_pkg::fe_req_t      dec_req_o
);

   typedef enum logic [1:0] {IDLE, BUSY, ACK, DROP} dec_state_t;

   dec_state_t state_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
         ack_o <= 1'b0;
         dec_valid_o <= 1'b0;
      end else begin
         dec_valid_o <= 1'b0;
         case (state_q)
            IDLE: begin
               if (req_i) begin
                  dec_valid_o <= 1'b1;
                  state_q <= BUSY;
               end
            end
            BUSY: begin
               // wait for the result stage
               if (fe_done_i) begin
                  ack_o <= 1'b1;
                  state_q <= ACK;
               end
            end
            ACK: begin
               if (!req_i) begin
                  ack_o <= 1'b0;
                  state_q <= DROP;
               end
            end
            // one guard cycle before the next request
            DROP: state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // request held stable for the whole transaction
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && req_i) begin
         dec_req_o <= fe_req_i;
      end
   end

   // requester must not change the request before it sees ack
   req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (req_i && $past(req_i) && !ack_o) |-> $stable(fe_req_i));

endmodule

`default_nettype wire

//--- cache_execute.sv
`default_nettype none

module cache_execute #(
   parameter int NWAYS = 2
) (
   input  wire                                 clk_i,
   input  wire                                 reset_i,
   input  wire                                 invalidate_i,
   input  wire                                 dec_valid_i,
   input  wire cache_addr_pkg::fe_req_t        dec_req_i,
   output logic                                fill_start_o,
   output cache_line_pkg::be_req_t             fill_req_o,
   input  wire                                 fill_done_i,
   input  wire cache_line_pkg::be_rsp_t        fill_line_i,
   output logic                                ex_valid_o,
   output logic                                ex_hit_o,
   output logic                                ex_we_o,
   output logic [cache_addr_pkg::OFFSET_W-1:0] ex_offset_o,
   output cache_line_pkg::line_t               ex_line_o
);

   localparam int WAY_W = (NWAYS > 1) ? $clog2(NWAYS) : 1;
   localparam int NLINES = 2 ** cache_addr_pkg::INDEX_W;
   localparam int BYTE_BITS = cache_addr_pkg::WORD_W / cache_addr_pkg::NBYTES;

   typedef enum logic [1:0] {E_IDLE, E_FILL, E_WRITE} ex_state_t;

   ex_state_t state_q;

   cache_line_pkg::tag_entry_t tags_q [NWAYS][NLINES];
   cache_line_pkg::line_t      lines_q [NWAYS][NLINES];
   logic [WAY_W-1:0]           rr_q [NLINES];

   logic [cache_addr_pkg::INDEX_W-1:0]  idx;
   logic [cache_addr_pkg::OFFSET_W-1:0] offset;
   logic [NWAYS-1:0]                    way_hit;
   logic [WAY_W-1:0]                    hit_way;
   logic                                hit;
   logic [WAY_W-1:0]                    victim_q;
   logic [WAY_W-1:0]                    hit_way_q;
   logic                                hit_q;

   // decode holds dec_req_i until the front end completes
   assign idx = dec_req_i.addr.fields.index;
   assign offset = dec_req_i.addr.fields.offset;
   assign hit = |way_hit;

   // tag compare on every way
   always_comb begin
      way_hit = '0;
      hit_way = '0;
      for (int w = 0; w < NWAYS; w++) begin
         way_hit[w] = tags_q[w][idx].valid &&
                      (tags_q[w][idx].tag == dec_req_i.addr.fields.tag);
         if (way_hit[w]) begin
            hit_way = WAY_W'(w);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= E_IDLE;
         fill_start_o <= 1'b0;
         ex_valid_o <= 1'b0;
         for (int i = 0; i < NLINES; i++) begin
            rr_q[i] <= '0;
            for (int w = 0; w < NWAYS; w++) begin
               tags_q[w][i] <= '0;
            end
         end
      end else begin
         fill_start_o <= 1'b0;
         ex_valid_o <= 1'b0;
         case (state_q)
            E_IDLE: begin
               if (dec_valid_i) begin
                  if (dec_req_i.we) begin
                     // every write goes through to memory
                     fill_start_o <= 1'b1;
                     state_q <= E_WRITE;
                  end else if (hit) begin
                     ex_valid_o <= 1'b1;
                  end else begin
                     fill_start_o <= 1'b1;
                     state_q <= E_FILL;
                  end
               end
            end
            E_FILL: begin
               if (fill_done_i) begin
                  tags_q[victim_q][idx].valid <= 1'b1;
                  tags_q[victim_q][idx].tag <= dec_req_i.addr.fields.tag;
                  // round-robin advance on the filled index only
                  rr_q[idx] <= (victim_q == WAY_W'(NWAYS - 1)) ? '0 : victim_q + 1'b1;
                  ex_valid_o <= 1'b1;
                  state_q <= E_IDLE;
               end
            end
            E_WRITE: begin
               if (fill_done_i) begin
                  ex_valid_o <= 1'b1;
                  state_q <= E_IDLE;
               end
            end
            default: state_q <= E_IDLE;
         endcase
         // invalidate wins over a fill in the same cycle
         if (invalidate_i) begin
            for (int i = 0; i < NLINES; i++) begin
               for (int w = 0; w < NWAYS; w++) begin
                  tags_q[w][i].valid <= 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == E_IDLE && dec_valid_i) begin
         victim_q <= rr_q[idx];
         hit_q <= hit;
         hit_way_q <= hit_way;
         fill_req_o.we <= dec_req_i.we;
         fill_req_o.waddr <= dec_req_i.addr.raw[cache_addr_pkg::ADDR_W-1:cache_addr_pkg::BSEL_W];
         fill_req_o.wdata <= dec_req_i.wdata;
         fill_req_o.wstrb <= dec_req_i.wstrb;
         ex_hit_o <= hit;
         ex_we_o <= dec_req_i.we;
         ex_offset_o <= offset;
         ex_line_o <= lines_q[hit_way][idx];
      end
      if (state_q == E_FILL && fill_done_i) begin
         lines_q[victim_q][idx] <= fill_line_i.line;
         ex_line_o <= fill_line_i.line;
      end
      // write hit merges once memory has taken the word
      if (state_q == E_WRITE && fill_done_i && hit_q) begin
         for (int b = 0; b < cache_addr_pkg::NBYTES; b++) begin
            if (dec_req_i.wstrb[b]) begin
               lines_q[hit_way_q][idx][offset][b*BYTE_BITS +: BYTE_BITS] <=
                  dec_req_i.wdata[b*BYTE_BITS +: BYTE_BITS];
            end
         end
      end
   end

   // a tag is never filled into two ways of one index
   way_hit_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
      dec_valid_i |-> $onehot0(way_hit));

   fill_done_pending_a: assert property (@(posedge clk_i) disable iff (reset_i)
      fill_done_i |-> (state_q != E_IDLE));

endmodule

`default_nettype wire

//--- cache_line_pkg.sv
`default_nettype none

package cache_line_pkg;

   localparam int LINE_WORDS = 4;
   localparam int LINE_W = LINE_WORDS * cache_addr_pkg::WORD_W;

   // word address on the back end, byte bits dropped
   localparam int WADDR_W = cache_addr_pkg::ADDR_W - cache_addr_pkg::BSEL_W;

   // one cache line, word 0 in the low bits
   typedef logic [LINE_WORDS-1:0][cache_addr_pkg::WORD_W-1:0] line_t;

   typedef struct packed {
      logic                             valid;
      logic [cache_addr_pkg::TAG_W-1:0] tag;
   } tag_entry_t;

   // reads fetch the aligned line, the low word bits are ignored
   typedef struct packed {
      logic                              we;
      logic [WADDR_W-1:0]                waddr;
      logic [cache_addr_pkg::WORD_W-1:0] wdata;
      logic [cache_addr_pkg::NBYTES-1:0] wstrb;
   } be_req_t;

   typedef struct packed {
      line_t line;
   } be_rsp_t;

endpackage

`default_nettype wire

//--- cache_refill.sv
`default_nettype none

module cache_refill (
   input  wire                          clk_i,
   input  wire                          reset_i,
   input  wire                          fill_start_i,
   input  wire cache_line_pkg::be_req_t fill_req_i,
   output cache_line_pkg::be_req_t      mem_req_o,
   output logic                         mem_req_valid_o,
   input  wire                          mem_ack_i,
   input  wire cache_line_pkg::be_rsp_t mem_rsp_i,
   output logic                         fill_done_o,
   output cache_line_pkg::be_rsp_t      fill_line_o
);

   typedef enum logic [1:0] {R_IDLE, R_WAIT_ACK, R_WAIT_DROP} rf_state_t;

   rf_state_t state_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= R_IDLE;
         mem_req_valid_o <= 1'b0;
         fill_done_o <= 1'b0;
      end else begin
         fill_done_o <= 1'b0;
         case (state_q)
            R_IDLE: begin
               if (fill_start_i) begin
                  mem_req_valid_o <= 1'b1;
                  state_q <= R_WAIT_ACK;
               end
            end
            R_WAIT_ACK: begin
               // line is valid with ack, release the request
               if (mem_ack_i) begin
                  mem_req_valid_o <= 1'b0;
                  state_q <= R_WAIT_DROP;
               end
            end
            R_WAIT_DROP: begin
               // memory has dropped ack, the handshake is closed
               if (!mem_ack_i) begin
                  fill_done_o <= 1'b1;
                  state_q <= R_IDLE;
               end
            end
            default: state_q <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == R_IDLE && fill_start_i) begin
         mem_req_o <= fill_req_i;
      end
      if (state_q == R_WAIT_ACK && mem_ack_i) begin
         fill_line_o <= mem_rsp_i;
      end
   end

   // slave answers only an open request
   mem_ack_rise_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(mem_ack_i) |-> mem_req_valid_o);

   // a second start would overwrite the request in flight
   fill_start_idle_a: assert property (@(posedge clk_i) disable iff (reset_i)
      fill_start_i |-> (state_q == R_IDLE));

endmodule

`default_nettype wire

//--- cache_result.sv
`default_nettype none

module cache_result (
   input  wire                                       clk_i,
   input  wire                                       reset_i,
   input  wire                                       ex_valid_i,
   input  wire                                       ex_hit_i,
   input  wire                                       ex_we_i,
   input  wire logic [cache_addr_pkg::OFFSET_W-1:0] ex_offset_i,
   input  wire cache_line_pkg::line_t                ex_line_i,
   output cache_addr_pkg::fe_rsp_t                   fe_rsp_o,
   output logic                                      fe_done_o,
   output logic                                      rd_hit_o,
   output logic                                      rd_miss_o,
   output logic                                      wr_hit_o,
   output logic                                      wr_miss_o
);

   logic rd;
   logic wr;

   assign rd = ex_valid_i & ~ex_we_i;
   assign wr = ex_valid_i & ex_we_i;

   // read word lands together with ack in decode
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fe_rsp_o <= '0;
      end else if (ex_valid_i) begin
         fe_rsp_o.rdata <= ex_line_i[ex_offset_i];
      end
   end

   // decode raises ack on the next edge
   assign fe_done_o = ex_valid_i;

   // monitor events, one per completed access
   assign rd_hit_o = rd & ex_hit_i;
   assign rd_miss_o = rd & ~ex_hit_i;
   assign wr_hit_o = wr & ex_hit_i;
   assign wr_miss_o = wr & ~ex_hit_i;

endmodule

`default_nettype wire

//--- cache_top.sv
`default_nettype none

module cache_top #(
   parameter int NWAYS = 2
) (
   input  wire                          clk_i,
   input  wire                          reset_i,
   // front end
   input  wire                          req_i,
   input  wire cache_addr_pkg::fe_req_t fe_req_i,
   output logic                         ack_o,
   output cache_addr_pkg::fe_rsp_t      fe_rsp_o,
   // monitor
   input  wire                          invalidate_i,
   output logic                         rd_hit_o,
   output logic                         rd_miss_o,
   output logic                         wr_hit_o,
   output logic                         wr_miss_o,
   // back end
   output cache_line_pkg::be_req_t      mem_req_o,
   output logic                         mem_req_valid_o,
   input  wire                          mem_ack_i,
   input  wire cache_line_pkg::be_rsp_t mem_rsp_i
);

   logic                                dec_valid;
   cache_addr_pkg::fe_req_t             dec_req;
   logic                                fill_start;
   cache_line_pkg::be_req_t             fill_req;
   logic                                fill_done;
   cache_line_pkg::be_rsp_t             fill_line;
   logic                                ex_valid;
   logic                                ex_hit;
   logic                                ex_we;
   logic [cache_addr_pkg::OFFSET_W-1:0] ex_offset;
   cache_line_pkg::line_t               ex_line;
   logic                                fe_done;

   cache_decode decode0 (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (req_i),
      .fe_req_i    (fe_req_i),
      .ack_o       (ack_o),
      .fe_done_i   (fe_done),
      .dec_valid_o (dec_valid),
      .dec_req_o   (dec_req)
   );

   cache_execute #(
      .NWAYS (NWAYS)
   ) execute0 (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .invalidate_i (invalidate_i),
      .dec_valid_i  (dec_valid),
      .dec_req_i    (dec_req),
      .fill_start_o (fill_start),
      .fill_req_o   (fill_req),
      .fill_done_i  (fill_done),
      .fill_line_i  (fill_line),
      .ex_valid_o   (ex_valid),
      .ex_hit_o     (ex_hit),
      .ex_we_o      (ex_we),
      .ex_offset_o  (ex_offset),
      .ex_line_o    (ex_line)
   );

   cache_refill refill0 (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .fill_start_i    (fill_start),
      .fill_req_i      (fill_req),
      .mem_req_o       (mem_req_o),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_ack_i       (mem_ack_i),
      .mem_rsp_i       (mem_rsp_i),
      .fill_done_o     (fill_done),
      .fill_line_o     (fill_line)
   );

   cache_result result0 (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .ex_valid_i  (ex_valid),
      .ex_hit_i    (ex_hit),
      .ex_we_i     (ex_we),
      .ex_offset_i (ex_offset),
      .ex_line_i   (ex_line),
      .fe_rsp_o    (fe_rsp_o),
      .fe_done_o   (fe_done),
      .rd_hit_o    (rd_hit_o),
      .rd_miss_o   (rd_miss_o),
      .wr_hit_o    (wr_hit_o),
      .wr_miss_o   (wr_miss_o)
   );

endmodule

`default_nettype wire

//--- src.f
cache_addr_pkg.sv
cache_line_pkg.sv
cache_decode.sv
cache_execute.sv
cache_refill.sv
cache_result.sv
cache_top.sv
tb_clock.sv
tb_cache_mem.sv
tb_cache.sv

//--- tb_cache.sv
`default_nettype none

module tb_cache;

   localparam int NWAYS = 2;
   localparam int NLINES = 16;
   localparam int NWORDS = 16384;
   // 300 transactions at 40 cycles worst case plus margin
   localparam int MAX_TRANS = 300;
   localparam int CYCLES_PER_TRANS = 40;
   localparam int TIMEOUT_CYCLES = MAX_TRANS * CYCLES_PER_TRANS + 8000;

   logic                          clk;
   logic                          reset_i;
   logic                          req_i;
   cache_addr_pkg::fe_req_t       fe_req_i;
   logic                          ack_o;
   cache_addr_pkg::fe_rsp_t       fe_rsp_o;
   logic                          invalidate_i;
   logic                          rd_hit_o;
   logic                          rd_miss_o;
   logic                          wr_hit_o;
   logic                          wr_miss_o;
   cache_line_pkg::be_req_t       mem_req;
   logic                          mem_req_valid;
   logic                          mem_ack;
   cache_line_pkg::be_rsp_t       mem_rsp;

   // reference model
   logic [31:0] ref_words [NWORDS];
   logic        ref_valid [NWAYS][NLINES];
   logic [7:0]  ref_tag [NWAYS][NLINES];
   int          ref_rr [NLINES];

   logic [15:0] lfsr_q;
   int          errors;
   int          checks;
   int          tests;
   int          cycles;
   int          n_rd_hit;
   int          n_rd_miss;
   int          n_wr_hit;
   int          n_wr_miss;
   // cycles of the last access until ack and until its monitor pulse
   int          ack_wait;
   int          pulse_wait;

   tb_clock clock0 (
      .clk_o (clk)
   );

   cache_top #(
      .NWAYS (NWAYS)
   ) dut0 (
      .clk_i           (clk),
      .reset_i         (reset_i),
      .req_i           (req_i),
      .fe_req_i        (fe_req_i),
      .ack_o           (ack_o),
      .fe_rsp_o        (fe_rsp_o),
      .invalidate_i    (invalidate_i),
      .rd_hit_o        (rd_hit_o),
      .rd_miss_o       (rd_miss_o),
      .wr_hit_o        (wr_hit_o),
      .wr_miss_o       (wr_miss_o),
      .mem_req_o       (mem_req),
      .mem_req_valid_o (mem_req_valid),
      .mem_ack_i       (mem_ack),
      .mem_rsp_i       (mem_rsp)
   );

   tb_cache_mem mem0 (
      .clk_i           (clk),
      .reset_i         (reset_i),
      .mem_req_i       (mem_req),
      .mem_req_valid_i (mem_req_valid),
      .mem_ack_o       (mem_ack),
      .mem_rsp_o       (mem_rsp)
   );

   // same start contents as the memory model
   function automatic logic [31:0] ref_init_word(input logic [13:0] a);
      ref_init_word = {~a[7:0], a[13:0] ^ 14'h2a5, a[9:0]};
   endfunction

   // 16-bit Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   function automatic logic [15:0] make_addr(input logic [7:0] tag, input logic [3:0] idx,
                                            input logic [1:0] off);
      make_addr = {tag, idx, off, 2'b00};
   endfunction

   function automatic logic model_hit(input logic [15:0] addr);
      model_hit = 1'b0;
      for (int w = 0; w < NWAYS; w++) begin
         if (ref_valid[w][addr[7:4]] && ref_tag[w][addr[7:4]] == addr[15:8]) begin
            model_hit = 1'b1;
         end
      end
   endfunction

   // a read miss fills the pointed way and moves the pointer on
   task automatic model_fill(input logic [15:0] addr);
      int w;
      w = ref_rr[addr[7:4]];
      ref_valid[w][addr[7:4]] = 1'b1;
      ref_tag[w][addr[7:4]] = addr[15:8];
      ref_rr[addr[7:4]] = (w + 1) % NWAYS;
   endtask

   task automatic tally_pulses;
      n_rd_hit += rd_hit_o;
      n_rd_miss += rd_miss_o;
      n_wr_hit += wr_hit_o;
      n_wr_miss += wr_miss_o;
   endtask

   task automatic check_flag(input string sig, input logic [15:0] addr, input logic got,
                             input logic exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %s at addr %h: got %h expected %h", sig, addr, got, exp);
         errors++;
      end
   endtask

   task automatic check_low_after_reset(input string sig, input logic got);
      checks++;
      if (got !== 1'b0) begin
         $display("[ERROR] %s after reset: got %h expected %h", sig, got, 1'b0);
         errors++;
      end
   endtask

   // one full four-phase front-end transaction
   task automatic fe_access(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic hit);
      logic got_ack;
      got_ack = 1'b0;
      n_rd_hit = 0;
      n_rd_miss = 0;
      n_wr_hit = 0;
      n_wr_miss = 0;
      ack_wait = 0;
      pulse_wait = 0;
      @(posedge clk);
      #10;
      fe_req_i.we = we;
      fe_req_i.addr.raw = addr;
      fe_req_i.wdata = wdata;
      fe_req_i.wstrb = wstrb;
      req_i = 1'b1;
      while (!got_ack) begin
         @(posedge clk);
         #10;
         ack_wait++;
         if (rd_hit_o || rd_miss_o || wr_hit_o || wr_miss_o) begin
            pulse_wait = ack_wait;
         end
         tally_pulses();
         got_ack = ack_o;
      end
      rdata = fe_rsp_o.rdata;
      req_i = 1'b0;
      while (ack_o) begin
         @(posedge clk);
         #10;
         tally_pulses();
      end
      checks++;
      if (n_rd_hit + n_rd_miss + n_wr_hit + n_wr_miss != 1) begin
         $display("access to %h raised %0d monitor pulses instead of exactly one", addr,
                  n_rd_hit + n_rd_miss + n_wr_hit + n_wr_miss);
         errors++;
      end
      checks++;
      if ((we && n_rd_hit + n_rd_miss != 0) || (!we && n_wr_hit + n_wr_miss != 0)) begin
         $display("access to %h raised a monitor pulse of the wrong direction", addr);
         errors++;
      end
      hit = we ? (n_wr_hit > 0) : (n_rd_hit > 0);
   endtask

   task automatic fe_read(input logic [15:0] addr, output logic [31:0] rdata,
                          output logic hit);
      logic exp_hit;
      exp_hit = model_hit(addr);
      fe_access(1'b0, addr, 32'h0, 4'h0, rdata, hit);
      check_flag("rd_hit_o", addr, hit, exp_hit);
      checks++;
      if (rdata !== ref_words[addr[15:2]]) begin
         $display("[ERROR] fe_rsp_o at addr %h: got %h expected %h", addr, rdata,
                  ref_words[addr[15:2]]);
         errors++;
      end
      // a read hit acks 3 cycles after the request is taken, its pulse 1 cycle earlier
      if (exp_hit) begin
         checks++;
         if (ack_wait != 3 || pulse_wait != 2) begin
            $display("read hit at %h acked after %0d cycles with its pulse after %0d,",
                     addr, ack_wait, pulse_wait);
            $display("while 3 and 2 cycles were expected");
            errors++;
         end
      end
      if (!exp_hit) begin
         model_fill(addr);
      end
   endtask

   task automatic fe_write(input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, output logic hit);
      logic        exp_hit;
      logic [31:0] unused;
      exp_hit = model_hit(addr);
      fe_access(1'b1, addr, wdata, wstrb, unused, hit);
      check_flag("wr_hit_o", addr, hit, exp_hit);
      for (int b = 0; b < 4; b++) begin
         if (wstrb[b]) begin
            ref_words[addr[15:2]][b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
   endtask

   task automatic pulse_invalidate;
      @(posedge clk);
      #10;
      invalidate_i = 1'b1;
      @(posedge clk);
      #10;
      invalidate_i = 1'b0;
      for (int i = 0; i < NLINES; i++) begin
         for (int w = 0; w < NWAYS; w++) begin
            ref_valid[w][i] = 1'b0;
         end
      end
   endtask

   task automatic report_test(input string name, input int err0);
      tests++;
      if (errors == err0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   task automatic test_reset_state;
      int err0;
      err0 = errors;
      check_low_after_reset("ack_o", ack_o);
      check_low_after_reset("mem_req_valid_o", mem_req_valid);
      check_low_after_reset("rd_hit_o", rd_hit_o);
      check_low_after_reset("rd_miss_o", rd_miss_o);
      check_low_after_reset("wr_hit_o", wr_hit_o);
      check_low_after_reset("wr_miss_o", wr_miss_o);
      report_test("reset_state", err0);
   endtask

   task automatic test_read_miss_hit;
      int          err0;
      logic [15:0] a;
      logic [31:0] d0;
      logic [31:0] d1;
      logic [31:0] exp;
      logic        h;
      err0 = errors;
      a = make_addr(8'h04, 4'h1, 2'd2);
      // untouched so far, memory still holds its start word
      exp = ref_init_word(a[15:2]);
      fe_read(a, d0, h);
      check_flag("rd_miss_o", a, !h, 1'b1);
      fe_read(a, d1, h);
      check_flag("rd_hit_o", a, h, 1'b1);
      checks++;
      if (d0 !== exp) begin
         $display("[ERROR] fe_rsp_o at addr %h: got %h expected %h", a, d0, exp);
         errors++;
      end
      checks++;
      if (d1 !== exp) begin
         $display("[ERROR] fe_rsp_o at addr %h: got %h expected %h", a, d1, exp);
         errors++;
      end
      report_test("read_miss_hit", err0);
   endtask

   task automatic test_write_through;
      int          err0;
      logic [15:0] a;
      logic [15:0] b;
      logic [31:0] d;
      logic        h;
      err0 = errors;
      a = make_addr(8'h07, 4'h2, 2'd0);
      b = make_addr(8'h09, 4'h3, 2'd3);
      fe_read(a, d, h);
      fe_write(a, 32'hdeadbeef, 4'b0101, h);
      check_flag("wr_hit_o", a, h, 1'b1);
      fe_read(a, d, h);
      check_flag("rd_hit_o", a, h, 1'b1);
      checks++;
      if (mem0.words[a[15:2]] !== ref_words[a[15:2]]) begin
         $display("[ERROR] mem word at addr %h: got %h expected %h", a,
                  mem0.words[a[15:2]], ref_words[a[15:2]]);
         errors++;
      end
      // no allocate on a write miss
      fe_write(b, 32'h12345678, 4'b1111, h);
      check_flag("wr_miss_o", b, !h, 1'b1);
      fe_read(b, d, h);
      check_flag("rd_miss_o", b, !h, 1'b1);
      report_test("write_through", err0);
   endtask

   task automatic test_round_robin;
      int          err0;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      logic [31:0] d;
      logic        h;
      err0 = errors;
      a = make_addr(8'h10, 4'h5, 2'd1);
      b = make_addr(8'h20, 4'h5, 2'd1);
      c = make_addr(8'h30, 4'h5, 2'd1);
      fe_read(a, d, h);
      check_flag("rd_miss_o", a, !h, 1'b1);
      fe_read(b, d, h);
      check_flag("rd_miss_o", b, !h, 1'b1);
      fe_read(c, d, h);
      check_flag("rd_miss_o", c, !h, 1'b1);
      fe_read(b, d, h);
      check_flag("rd_hit_o", b, h, 1'b1);
      // C went into the way that held A
      fe_read(a, d, h);
      check_flag("rd_miss_o", a, !h, 1'b1);
      report_test("round_robin", err0);
   endtask

   task automatic test_invalidate;
      int          err0;
      logic [15:0] a;
      logic [31:0] d;
      logic        h;
      err0 = errors;
      a = make_addr(8'h04, 4'h1, 2'd2);
      fe_read(a, d, h);
      check_flag("rd_hit_o", a, h, 1'b1);
      pulse_invalidate();
      fe_read(a, d, h);
      check_flag("rd_miss_o", a, !h, 1'b1);
      report_test("invalidate", err0);
   endtask

   task automatic test_random_mix;
      int          err0;
      logic [31:0] op;
      logic [31:0] tsel;
      logic [31:0] isel;
      logic [31:0] osel;
      logic [31:0] wdata;
      logic [31:0] strb;
      logic [31:0] d;
      logic [15:0] a;
      logic        h;
      err0 = errors;
      for (int i = 0; i < 200; i++) begin
         draw_bits(2, op);
         draw_bits(2, tsel);
         draw_bits(2, isel);
         draw_bits(2, osel);
         // few tags on few indexes so lines conflict
         a = make_addr({6'b100000, tsel[1:0]}, {2'b10, isel[1:0]}, osel[1:0]);
         if (op[1:0] == 2'd0) begin
            draw_bits(32, wdata);
            draw_bits(4, strb);
            if (strb[3:0] == 4'h0) begin
               strb[3:0] = 4'hf;
            end
            fe_write(a, wdata, strb[3:0], h);
         end else begin
            fe_read(a, d, h);
         end
      end
      report_test("random_mix", err0);
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, a handshake never completed", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      req_i = 1'b0;
      fe_req_i = '0;
      invalidate_i = 1'b0;
      reset_i = 1'b1;
      lfsr_q = 16'd43324;
      errors = 0;
      checks = 0;
      tests = 0;
      cycles = 0;
      ack_wait = 0;
      pulse_wait = 0;
      for (int a = 0; a < NWORDS; a++) begin
         ref_words[a] = ref_init_word(14'(a));
      end
      for (int i = 0; i < NLINES; i++) begin
         ref_rr[i] = 0;
         for (int w = 0; w < NWAYS; w++) begin
            ref_valid[w][i] = 1'b0;
            ref_tag[w][i] = '0;
         end
      end
      repeat (10) @(posedge clk);
      #10;
      reset_i = 1'b0;
      test_reset_state();
      test_read_miss_hit();
      test_write_through();
      test_round_robin();
      test_invalidate();
      test_random_mix();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_cache_mem.sv
`default_nettype none

module tb_cache_mem #(
   parameter int LATENCY = 3
) (
   input  wire                          clk_i,
   input  wire                          reset_i,
   input  wire cache_line_pkg::be_req_t mem_req_i,
   input  wire                          mem_req_valid_i,
   output logic                         mem_ack_o,
   output cache_line_pkg::be_rsp_t      mem_rsp_o
);

   localparam int NWORDS = 2 ** cache_line_pkg::WADDR_W;

   logic [31:0] words [NWORDS];
   int          wait_q;

   // every word differs from its neighbours across the whole address
   function automatic logic [31:0] fill_word(input logic [13:0] a);
      fill_word = {~a[7:0], a[13:0] ^ 14'h2a5, a[9:0]};
   endfunction

   initial begin
      for (int a = 0; a < NWORDS; a++) begin
         words[a] = fill_word(14'(a));
      end
      mem_ack_o = 1'b0;
      mem_rsp_o = '0;
      wait_q = 0;
   end

   always @(posedge clk_i) begin
      if (reset_i) begin
         mem_ack_o <= 1'b0;
         wait_q <= 0;
      end else if (!mem_ack_o && mem_req_valid_i) begin
         if (wait_q < LATENCY) begin
            wait_q <= wait_q + 1;
         end else begin
            wait_q <= 0;
            mem_ack_o <= 1'b1;
            if (mem_req_i.we) begin
               for (int b = 0; b < cache_addr_pkg::NBYTES; b++) begin
                  if (mem_req_i.wstrb[b]) begin
                     words[mem_req_i.waddr][b*8 +: 8] <= mem_req_i.wdata[b*8 +: 8];
                  end
               end
            end else begin
               // aligned line, low word bits ignored
               for (int w = 0; w < cache_line_pkg::LINE_WORDS; w++) begin
                  mem_rsp_o.line[w] <= words[{mem_req_i.waddr[13:2], w[1:0]}];
               end
            end
         end
      end else if (mem_ack_o && !mem_req_valid_i) begin
         mem_ack_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk_o
);

   localparam int HALF_PERIOD = 50;

   // free running, first rising edge at 50
   initial begin
      clk_o = 1'b0;
      forever begin
         #HALF_PERIOD clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire
